// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_rr_f2f
FILELIST  := sim.f
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/rr_cfg_pkg.sv
/* sizing constants of the round-robin fifo-to-fifo engine
   imported by the channel package, the head interface and every stage */
package rr_cfg_pkg;

   // channel counts on each side
   localparam int NUM_IN  = 4;
   localparam int NUM_OUT = 3;

   // head order spans the wider side
   // positions past the narrower side never go
   localparam int MAX_IO = (NUM_IN > NUM_OUT) ? NUM_IN : NUM_OUT;

   // payload width of one fifo word
   localparam int WORD_W = 8;

   // round-robin pointers
   // one spare bit so a pointer that runs past its channel count shows up
   localparam int IPTR_W = $clog2(NUM_IN) + 1;
   localparam int OPTR_W = $clog2(NUM_OUT) + 1;

   // width of a per-cycle move count, 0 .. MAX_IO inclusive
   localparam int CNT_W = $clog2(MAX_IO + 1);

endpackage

// File: hw/rr_chan_pkg.sv
/* channel-level types and the helper functions shared by the engine stages
   and the testbench: move count of a go run and modular pointer advance */
package rr_chan_pkg;

   import rr_cfg_pkg::*;

   // one fifo word
   typedef logic [WORD_W-1:0] word_t;

   // one bit per channel, bit n is channel n
   typedef logic [NUM_IN-1:0]  in_vec_t;
   typedef logic [NUM_OUT-1:0] out_vec_t;

   // one bit per head position, position 0 has the turn
   typedef logic [MAX_IO-1:0]  go_vec_t;

   // number of words that move with this go run
   function automatic logic [CNT_W-1:0] count_go(go_vec_t go);
      logic [CNT_W-1:0] cnt;
      cnt = '0;
      for (int p = 0; p < MAX_IO; p++)
      begin
         cnt = cnt + CNT_W'(go[p]);
      end
      return cnt;
   endfunction

   // ptr + cnt wrapped into 0 .. n-1
   // ptr is below n and cnt is at most n, so one subtraction is enough
   // also used for the rotators, where cnt is a head position or n - ptr
   function automatic int unsigned advance_ptr(int unsigned ptr,
                                               int unsigned cnt,
                                               int unsigned n);
      int unsigned sum;
      sum = ptr + cnt;
      if (sum >= n)
      begin
         sum = sum - n;
      end
      return sum;
   endfunction

endpackage

// File: hw/rr_f2f_top.sv
/* round-robin fifo-to-fifo transfer engine, valid/yumi on the input fifos and
   ready/valid on the output fifos, whole path combinational in one cycle */
`timescale 1ns/1ps

module rr_f2f_top (
   input  logic                  clk,
   input  logic                  reset,

   // input fifos
   // a yumi pulse dequeues the word at this edge
   input  rr_chan_pkg::in_vec_t  valid_i,
   input  rr_chan_pkg::word_t    data_i [rr_cfg_pkg::NUM_IN],
   output rr_chan_pkg::in_vec_t  yumi_o,

   // output fifos
   // a valid pulse enqueues the word at this edge
   output rr_chan_pkg::out_vec_t valid_o,
   output rr_chan_pkg::word_t    data_o [rr_cfg_pkg::NUM_OUT],
   input  rr_chan_pkg::out_vec_t ready_i
);

   // head-order view shared by the three stages
   rr_head_if head_bus ();

   // decode
   // input side into head order, yumis back out
   rr_in_rotate u_in_rotate (
      .clk     (clk),
      .reset   (reset),
      .valid_i (valid_i),
      .data_i  (data_i),
      .yumi_o  (yumi_o),
      .head    (head_bus.decode)
   );

   // execute
   // picks the contiguous run that moves this cycle
   rr_go_select u_go_select (
      .head (head_bus.execute)
   );

   // result
   // output readies into head order, valids and words back out
   rr_out_rotate u_out_rotate (
      .clk     (clk),
      .reset   (reset),
      .ready_i (ready_i),
      .valid_o (valid_o),
      .data_o  (data_o),
      .head    (head_bus.result)
   );

endmodule

// File: hw/rr_go_select.sv
/* execute stage: combines head valids and head readies into the go run
   only the unbroken run from position 0 moves, keeping rigid round-robin order */
`timescale 1ns/1ps

module rr_go_select (
   rr_head_if.execute head
);

   import rr_cfg_pkg::*;
   import rr_chan_pkg::*;

   // both views widened to MAX_IO
   // positions past a side's channel count read as zero and never go
   go_vec_t valid_pad;
   go_vec_t ready_pad;

   // positions where a word is offered and a slot is free
   go_vec_t both;

   assign valid_pad = go_vec_t'(head.head_valid);
   assign ready_pad = go_vec_t'(head.head_ready);
   assign both      = valid_pad & ready_pad;

   // prefix and from position 0
   // the first position that cannot move stops the run
   // so a blocked head gives an empty run
   always_comb
   begin
      go_vec_t run;
      run[0] = both[0];
      for (int p = 1; p < MAX_IO; p++)
      begin
         run[p] = run[p-1] & both[p];
      end
      head.go = run;
   end

endmodule

// File: hw/rr_head_if.sv
/* head-order view shared by the decode, execute and result stages
   position 0 is the input and the output channel whose turn it is */
`timescale 1ns/1ps

interface rr_head_if;

   import rr_cfg_pkg::*;
   import rr_chan_pkg::*;

   // input valids and words, rotated so position 0 is the input turn
   in_vec_t  head_valid;
   word_t    head_data [NUM_IN];

   // output readies, rotated so position 0 is the output turn
   out_vec_t head_ready;

   // contiguous run of head positions that move this cycle
   go_vec_t  go;

   // decode side: publishes the input view, counts go for its pointer
   modport decode (
      output head_valid,
      output head_data,
      input  go
   );

   // execute side: pure combine of both views into the go run
   modport execute (
      input  head_valid,
      input  head_ready,
      output go
   );

   // result side: publishes the output view, takes go and the words
   modport result (
      output head_ready,
      input  head_data,
      input  go
   );

endinterface

// File: hw/rr_in_rotate.sv
/* decode stage: rotates the input valids and words into head order by the input
   pointer, and rotates the go run back onto the input channels as yumis */
`timescale 1ns/1ps

module rr_in_rotate (
   input  logic                clk,
   input  logic                reset,
   input  rr_chan_pkg::in_vec_t valid_i,
   input  rr_chan_pkg::word_t  data_i [rr_cfg_pkg::NUM_IN],
   output rr_chan_pkg::in_vec_t yumi_o,
   rr_head_if.decode           head
);

   import rr_cfg_pkg::*;
   import rr_chan_pkg::*;

   // input channel that has the turn
   logic [IPTR_W-1:0] iptr_r;
   logic [IPTR_W-1:0] iptr_n;

   // words taken this cycle
   logic [CNT_W-1:0]  go_cnt;

   // head position h sees input channel (iptr + h) mod NUM_IN
   always_comb
   begin
      int unsigned src;
      for (int h = 0; h < NUM_IN; h++)
      begin
         src = advance_ptr(iptr_r, h, NUM_IN);
         head.head_valid[h] = valid_i[src];
         head.head_data[h]  = data_i[src];
      end
   end

   // inverse rotation for the yumis
   // channel c sits at head position (c - iptr) mod NUM_IN
   // NUM_IN - iptr keeps the wrap on the add side
   always_comb
   begin
      int unsigned pos;
      for (int c = 0; c < NUM_IN; c++)
      begin
         pos = advance_ptr(c, NUM_IN - iptr_r, NUM_IN);
         yumi_o[c] = head.go[pos];
      end
   end

   // pointer moves past every word taken
   // an empty run leaves it where it is
   assign go_cnt = count_go(head.go);
   assign iptr_n = IPTR_W'(advance_ptr(iptr_r, go_cnt, NUM_IN));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         iptr_r <= '0;
      end
      else
      begin
         iptr_r <= iptr_n;
      end
   end

   // go comes from the execute stage, so this ties both stages together
   yumi_needs_valid: assert property (@(posedge clk) (yumi_o & ~valid_i) == '0)
      else $error("yumi without valid: yumi_o=%h valid_i=%h", yumi_o, valid_i);

   // pointer stays a channel number across every advance
   iptr_in_range: assert property (@(posedge clk) disable iff (reset) iptr_r < NUM_IN)
      else $error("input pointer out of range: iptr_r=%h", iptr_r);

endmodule

// File: hw/rr_out_rotate.sv
/* result stage: rotates output readies into head order by the output pointer,
   and maps the go run and the head words back onto the output channels */
`timescale 1ns/1ps

module rr_out_rotate (
   input  logic                  clk,
   input  logic                  reset,
   input  rr_chan_pkg::out_vec_t ready_i,
   output rr_chan_pkg::out_vec_t valid_o,
   output rr_chan_pkg::word_t    data_o [rr_cfg_pkg::NUM_OUT],
   rr_head_if.result             head
);

   import rr_cfg_pkg::*;
   import rr_chan_pkg::*;

   // output channel that has the turn
   logic [OPTR_W-1:0] optr_r;
   logic [OPTR_W-1:0] optr_n;

   // words delivered this cycle
   logic [CNT_W-1:0]  go_cnt;

   // head words, one per output head position
   // positions past NUM_IN hold zero and never go
   word_t data_pad [NUM_OUT];

   // head position h sees output channel (optr + h) mod NUM_OUT
   always_comb
   begin
      int unsigned src;
      for (int h = 0; h < NUM_OUT; h++)
      begin
         src = advance_ptr(optr_r, h, NUM_OUT);
         head.head_ready[h] = ready_i[src];
      end
   end

   // trim or pad the input-side words to the output side
   always_comb
   begin
      for (int p = 0; p < NUM_OUT; p++)
      begin
         if (p < NUM_IN)
         begin
            data_pad[p] = head.head_data[p];
         end
         else
         begin
            data_pad[p] = '0;
         end
      end
   end

   // inverse rotation onto the output channels
   // channel c takes head position (c - optr) mod NUM_OUT
   // data follows whether or not the channel gets a valid pulse
   always_comb
   begin
      int unsigned pos;
      for (int c = 0; c < NUM_OUT; c++)
      begin
         pos = advance_ptr(c, NUM_OUT - optr_r, NUM_OUT);
         valid_o[c] = head.go[pos];
         data_o[c]  = data_pad[pos];
      end
   end

   // same count as the input side, so both pointers move together
   // go never reaches past NUM_OUT, the padded readies are zero there
   assign go_cnt = count_go(head.go);
   assign optr_n = OPTR_W'(advance_ptr(optr_r, go_cnt, NUM_OUT));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         optr_r <= '0;
      end
      else
      begin
         optr_r <= optr_n;
      end
   end

   // go also depends on the input side, so this spans all three stages
   valid_needs_ready: assert property (@(posedge clk) (valid_o & ~ready_i) == '0)
      else $error("valid without ready: valid_o=%h ready_i=%h", valid_o, ready_i);

   // pointer stays a channel number across every advance
   optr_in_range: assert property (@(posedge clk) disable iff (reset) optr_r < NUM_OUT)
      else $error("output pointer out of range: optr_r=%h", optr_r);

endmodule

// File: sim.f
hw/rr_cfg_pkg.sv
hw/rr_chan_pkg.sv
hw/rr_head_if.sv
hw/rr_in_rotate.sv
hw/rr_go_select.sv
hw/rr_out_rotate.sv
hw/rr_f2f_top.sv
testbench/tb_rr_f2f.sv

// File: testbench/tb_rr_f2f.sv
/* testbench for the round-robin fifo-to-fifo engine with random valid and ready levels
   reference pointers follow a running word count, concurrent assertions do the checks */
`timescale 1ns/1ps

module tb_rr_f2f;

   import rr_cfg_pkg::*;
   import rr_chan_pkg::*;

   // a run can never be longer than the narrower side
   localparam int MIN_IO       = (NUM_IN < NUM_OUT) ? NUM_IN : NUM_OUT;
   // word layout is channel number on top, sequence count below
   localparam int CH_W         = 2;
   localparam int SEQ_W        = WORD_W - CH_W;
   localparam int RUN_CYCLES   = 2000;
   localparam int MOVE_TIMEOUT = 64;

   logic     clk;
   logic     reset;
   in_vec_t  valid_i;
   word_t    data_i [NUM_IN];
   in_vec_t  yumi_o;
   out_vec_t valid_o;
   word_t    data_o [NUM_OUT];
   out_vec_t ready_i;

   // xorshift state
   logic [31:0] rng_r;

   // reference state
   // words moved since reset, words taken per input, words seen per source at the outputs
   int unsigned      total_r = 0;
   logic [SEQ_W-1:0] in_seq_r [NUM_IN] = '{default: '0};
   logic [SEQ_W-1:0] out_seq_r [NUM_IN] = '{default: '0};

   // expected response for the current levels
   int unsigned      exp_iptr;
   int unsigned      exp_optr;
   int unsigned      exp_len;
   in_vec_t          exp_yumi;
   out_vec_t         exp_valid;
   logic             blocked;
   logic             data_ok;
   word_t            data_got;
   word_t            data_exp;
   logic             seq_ok;
   logic [SEQ_W-1:0] seq_got;
   logic [SEQ_W-1:0] seq_exp;

   rr_f2f_top u_dut (
      .clk     (clk),
      .reset   (reset),
      .valid_i (valid_i),
      .data_i  (data_i),
      .yumi_o  (yumi_o),
      .valid_o (valid_o),
      .data_o  (data_o),
      .ready_i (ready_i)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift32(logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // each input fifo shows its channel number and how many words it gave up
   always_comb
   begin
      for (int c = 0; c < NUM_IN; c++)
      begin
         data_i[c] = {CH_W'(c), in_seq_r[c]};
      end
   end

   // reference counters advance on the cycle just ended
   always @(posedge clk)
   begin
      if (reset)
      begin
         total_r <= 0;
         for (int c = 0; c < NUM_IN; c++)
         begin
            in_seq_r[c]  <= '0;
            out_seq_r[c] <= '0;
         end
      end
      else
      begin
         total_r <= total_r + exp_len;
         for (int c = 0; c < NUM_IN; c++)
         begin
            if (yumi_o[c])
            begin
               in_seq_r[c] <= in_seq_r[c] + 1'b1;
            end
         end
         // source channel taken from the delivered word itself
         for (int o = 0; o < NUM_OUT; o++)
         begin
            if (valid_o[o])
            begin
               out_seq_r[data_o[o][WORD_W-1 -: CH_W]] <=
                  out_seq_r[data_o[o][WORD_W-1 -: CH_W]] + 1'b1;
            end
         end
      end
   end

   // rigid order
   // head h pairs input (total + h) mod NUM_IN with output (total + h) mod NUM_OUT
   always_comb
   begin
      int unsigned src;
      int unsigned dst;
      logic        run;
      exp_iptr  = total_r % NUM_IN;
      exp_optr  = total_r % NUM_OUT;
      exp_len   = 0;
      exp_yumi  = '0;
      exp_valid = '0;
      data_ok   = 1'b1;
      data_got  = '0;
      data_exp  = '0;
      run       = 1'b1;
      for (int h = 0; h < MIN_IO; h++)
      begin
         src = (exp_iptr + h) % NUM_IN;
         dst = (exp_optr + h) % NUM_OUT;
         run = run & valid_i[src] & ready_i[dst];
         if (run)
         begin
            exp_yumi[src]  = 1'b1;
            exp_valid[dst] = 1'b1;
            exp_len        = exp_len + 1;
            if (data_o[dst] != data_i[src])
            begin
               data_ok  = 1'b0;
               data_got = data_o[dst];
               data_exp = data_i[src];
            end
         end
      end
      blocked = !valid_i[exp_iptr] || !ready_i[exp_optr];
   end

   // every delivered word is the next one from its source fifo
   always_comb
   begin
      logic [CH_W-1:0] ch;
      seq_ok  = 1'b1;
      seq_got = '0;
      seq_exp = '0;
      ch      = '0;
      for (int o = 0; o < NUM_OUT; o++)
      begin
         ch = data_o[o][WORD_W-1 -: CH_W];
         if (valid_o[o] && data_o[o][SEQ_W-1:0] != out_seq_r[ch])
         begin
            seq_ok  = 1'b0;
            seq_got = data_o[o][SEQ_W-1:0];
            seq_exp = out_seq_r[ch];
         end
      end
   end

   task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
      $display("TB FAILED");
      $display("error %s got %h expected %h", name, got, exp);
      $fatal(1, "check on %s did not hold", name);
   endtask

   // checks sample at the falling edge, half a cycle after the inputs changed
   idle_no_yumi: assert property (@(negedge clk)
      (valid_i != '0 && !reset) || yumi_o == '0)
      else report_value("yumi_o", 32'(yumi_o), 32'h0);
   idle_no_valid: assert property (@(negedge clk)
      (valid_i != '0 && !reset) || valid_o == '0)
      else report_value("valid_o", 32'(valid_o), 32'h0);
   yumi_in_order: assert property (@(negedge clk) disable iff (reset) yumi_o == exp_yumi)
      else report_value("yumi_o", 32'(yumi_o), 32'(exp_yumi));
   valid_in_order: assert property (@(negedge clk) disable iff (reset) valid_o == exp_valid)
      else report_value("valid_o", 32'(valid_o), 32'(exp_valid));
   blocked_no_yumi: assert property (@(negedge clk) disable iff (reset)
      !blocked || yumi_o == '0)
      else report_value("yumi_o", 32'(yumi_o), 32'h0);
   blocked_no_valid: assert property (@(negedge clk) disable iff (reset)
      !blocked || valid_o == '0)
      else report_value("valid_o", 32'(valid_o), 32'h0);
   counts_agree: assert property (@(negedge clk) disable iff (reset)
      $countones(yumi_o) == $countones(valid_o))
      else report_value("valid_o count", 32'($countones(valid_o)), 32'($countones(yumi_o)));
   data_follows_input: assert property (@(negedge clk) disable iff (reset) data_ok)
      else report_value("data_o", 32'(data_got), 32'(data_exp));
   seq_is_next: assert property (@(negedge clk) disable iff (reset) seq_ok)
      else report_value("data_o sequence", 32'(seq_got), 32'(seq_exp));
   full_moves_num_out: assert property (@(negedge clk) disable iff (reset)
      !(valid_i == '1 && ready_i == '1) || ($countones(valid_o) == NUM_OUT))
      else report_value("valid_o", 32'(valid_o), 32'((1 << NUM_OUT) - 1));
   yumi_has_valid: assert property (@(negedge clk) (yumi_o & ~valid_i) == '0)
      else report_value("yumi_o", 32'(yumi_o), 32'(yumi_o & valid_i));
   valid_has_ready: assert property (@(negedge clk) (valid_o & ~ready_i) == '0)
      else report_value("valid_o", 32'(valid_o), 32'(valid_o & ready_i));

   // about one cycle in sixteen offers no word at all
   task automatic drive_random_levels();
      @(posedge clk);
      rng_r = xorshift32(rng_r);
      ready_i <= rng_r[10:8] | rng_r[13:11];
      if (rng_r[20:17] == 4'h0)
      begin
         valid_i <= '0;
      end
      else
      begin
         valid_i <= rng_r[3:0] | rng_r[7:4];
      end
   endtask

   task automatic drive_full_levels();
      @(posedge clk);
      valid_i <= '1;
      ready_i <= '1;
   endtask

   task automatic wait_for_first_move();
      int waited;
      waited = 0;
      while (total_r == 0 && waited < MOVE_TIMEOUT)
      begin
         drive_random_levels();
         waited = waited + 1;
      end
      if (total_r == 0)
      begin
         $display("TB FAILED");
         $display("no word moved within %0d cycles after reset", MOVE_TIMEOUT);
         $fatal(1, "transfer timeout");
      end
   endtask

   initial
   begin
      clk     = 1'b0;
      reset   = 1'b1;
      valid_i = '0;
      ready_i = '0;
      rng_r   = 32'd14;
      // readies toggle under reset, valids stay low
      for (int i = 0; i < 8; i++)
      begin
         @(posedge clk);
         rng_r = xorshift32(rng_r);
         ready_i <= rng_r[2:0];
      end
      reset <= 1'b0;
      wait_for_first_move();
      // a short burst of full levels every 500 cycles
      for (int cycle = 0; cycle < RUN_CYCLES; cycle++)
      begin
         if (cycle % 500 < 6)
         begin
            drive_full_levels();
         end
         else
         begin
            drive_random_levels();
         end
      end
      @(posedge clk);
      valid_i <= '0;
      @(posedge clk);
      $display("TB PASSED");
      $finish;
   end

endmodule
